// File: files.f
+incdir+src
src/bp_pkg.sv
src/ex_pkg.sv
src/ex_slot_if.sv
src/bp_upd_if.sv
src/ex_collect.sv
src/update_merge_buffer.sv
src/predictor_update.sv
src/bp_update_top.sv
tb/bp_update_assertions.sv
tb/tb_bp_update.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; the exit status is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_bp_update -f files.f -o tb_bp_update
./obj_dir/tb_bp_update

// File: tb/tb_bp_update.sv
// testbench for the predictor update path; applies a lane table and checks records and lookups
`timescale 1ns/1ns
`include "bp_params.svh"

module tb_bp_update;
    import bp_pkg::*;
    import ex_pkg::*;

    localparam int PC_W       = `PC_W;
    localparam int ENTRIES    = 1 << `BTB_IDX_W;
    localparam int RST_CYCLES = 16;

    typedef struct packed {
        logic         dual;
        logic         stall;
        logic         rnd;      // outcomes drawn at apply time
        lane_result_t l0;
        lane_result_t l1;
    } row_t;

    logic            clk;
    logic            rstn;
    logic            stall;
    logic            dual;
    lane_result_t    lane0;
    lane_result_t    lane1;
    logic            upd_valid;
    logic [PC_W-1:0] upd_pc;
    logic            upd_taken;
    logic [2:0]      upd_kind;
    logic [PC_W-1:0] upd_target;
    logic            mispredict;
    logic [PC_W-1:0] lookup_pc;
    logic            lookup_taken;
    logic [PC_W-1:0] lookup_target;

    row_t            rows[$];
    lane_result_t    stream[$];     // enqueued lanes not yet in a pack
    upd_rec_t        exp_q[$];
    logic [1:0]      m_cnt [ENTRIES];
    logic [PC_W-1:0] m_tgt [ENTRIES];
    logic            exp_miss;
    int              cycles = 0;

    bp_update_top i_bp_update_top (
        .*,
        .lane0_pred_taken  (lane0.meta.taken),
        .lane0_pred_kind   (lane0.meta.kind),
        .lane0_pred_npc    (lane0.meta.npc),
        .lane0_pred_choice (lane0.meta.choice),
        .lane0_taken       (lane0.taken),
        .lane0_kind        (lane0.kind),
        .lane0_npc         (lane0.npc),
        .lane0_pc          (lane0.pc),
        .lane0_cut         (lane0.cut),
        .lane1_pred_taken  (lane1.meta.taken),
        .lane1_pred_kind   (lane1.meta.kind),
        .lane1_pred_npc    (lane1.meta.npc),
        .lane1_pred_choice (lane1.meta.choice),
        .lane1_taken       (lane1.taken),
        .lane1_kind        (lane1.kind),
        .lane1_npc         (lane1.npc),
        .lane1_pc          (lane1.pc),
        .lane1_cut         (lane1.cut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > RST_CYCLES + rows.size() + 2 * ENTRIES + 40) begin
            report_failure("timeout: the run did not finish within its cycle limit");
        end
    end

    // flags are {taken, predicted taken, cut}
    function automatic lane_result_t make_lane(input logic [PC_W-1:0] pc,
                                               input logic [PC_W-1:0] npc,
                                               input br_kind_t kind, input logic [2:0] flags,
                                               input logic [PC_W-1:0] pnpc);
        lane_result_t l;
        l.pc          = pc;
        l.npc         = npc;
        l.kind        = kind;
        l.taken       = flags[2];
        l.meta.taken  = flags[1];
        l.cut         = flags[0];
        l.meta.npc    = pnpc;
        l.meta.kind   = kind;
        l.meta.choice = pc[1:0];
        return l;
    endfunction

    function automatic lane_result_t shuffle_outcome(input lane_result_t l);
        lane_result_t o;
        logic [2:0]   k;
        o           = l;
        k           = 3'($urandom % 6);
        o.kind      = br_kind_t'(k);
        o.taken     = 1'($urandom);
        o.npc       = PC_W'($urandom);
        o.meta.kind = o.kind;
        o.meta.taken = 1'($urandom);
        o.meta.npc  = ($urandom % 4 != 0) ? o.npc : PC_W'($urandom);  // mostly right target
        return o;
    endfunction

    function automatic int kind_rank(input br_kind_t k);
        case (k)
            direct_jump:   return 5;
            call:          return 4;
            ret:           return 3;
            indirect_jump: return 2;
            other_jump:    return 1;
            default:       return 0;
        endcase
    endfunction

    task automatic add_row(input logic [2:0] flags, input lane_result_t l0,
                           input lane_result_t l1);
        rows.push_back({flags, l0, l1});
    endtask

    task automatic build_table();
        lane_result_t idle;
        idle = '0;
        // row flags {dual, stall, rnd}
        add_row(3'b100, make_lane(30'h100, 30'h101, not_jump, 3'b000, 30'h101),
                make_lane(30'h101, 30'h240, direct_jump, 3'b110, 30'h240));
        add_row(3'b100, make_lane(30'h203, 30'h300, call, 3'b110, 30'h300),
                make_lane(30'h204, 30'h400, ret, 3'b110, 30'h400));
        add_row(3'b100, make_lane(30'h213, 30'h500, ret, 3'b110, 30'h300),   // wrong target
                make_lane(30'h214, 30'h215, indirect_jump, 3'b000, 30'h215));
        add_row(3'b110, make_lane(30'h3f0, 30'h3f1, call, 3'b110, 30'h3f1), idle);
        add_row(3'b000, make_lane(30'h223, 30'h600, other_jump, 3'b101, 30'h224), idle);
        add_row(3'b100, make_lane(30'h233, 30'h700, indirect_jump, 3'b111, 30'h700),
                make_lane(30'h305, 30'h306, not_jump, 3'b000, 30'h306));
        add_row(3'b100, make_lane(30'h315, 30'h316, other_jump, 3'b010, 30'h380),
                make_lane(30'h316, 30'h800, call, 3'b110, 30'h800));
        add_row(3'b100, make_lane(30'h325, 30'h900, ret, 3'b110, 30'h900),
                make_lane(30'h326, 30'h327, not_jump, 3'b000, 30'h327));
        add_row(3'b000, make_lane(30'h335, 30'ha00, direct_jump, 3'b100, 30'h336), idle);
        add_row(3'b010, idle, idle);
        for (int i = 0; i < 6; i++) begin
            add_row(3'b101, make_lane(PC_W'('h400 + 2 * i), '0, not_jump, 3'b000, '0),
                    make_lane(PC_W'('h401 + 2 * i), '0, not_jump, 3'b000, '0));
        end
        add_row(3'b000, make_lane(30'h345, 30'h346, not_jump, 3'b001, 30'h346), idle);
        add_row(3'b100, make_lane(30'h3a7, 30'hb00, direct_jump, 3'b110, 30'hb00),
                make_lane(30'h3a8, 30'h3a9, not_jump, 3'b000, 30'h3a9));
    endtask

    // a cut head closes its pack alone and anything else pairs with the next lane
    task automatic form_packs();
        lane_result_t a;
        lane_result_t b;
        upd_rec_t     r;
        while (stream.size() >= 2 || (stream.size() == 1 && stream[0].cut)) begin
            a        = stream.pop_front();
            r.pc     = a.pc;
            r.meta   = a.meta;
            r.taken  = a.taken;
            r.kind   = a.kind;
            r.target = a.npc;
            if (!a.cut) begin
                b        = stream.pop_front();
                r.taken  = a.taken | b.taken;
                r.kind   = (kind_rank(a.kind) >= kind_rank(b.kind)) ? a.kind : b.kind;
                r.target = a.taken ? a.npc : b.npc;
            end
            exp_q.push_back(r);
        end
    endtask

    task automatic apply_row(input row_t r);
        if (r.rnd) begin
            r.l0 = shuffle_outcome(r.l0);
            r.l1 = shuffle_outcome(r.l1);
        end
        @(posedge clk);
        stall <= r.stall;
        dual  <= r.dual;
        lane0 <= r.l0;
        lane1 <= r.l1;
        if (!r.stall) begin
            stream.push_back(r.l0);
            if (r.dual) begin
                stream.push_back(r.l1);
            end
        end
        form_packs();
    endtask

    task automatic check_record();
        upd_rec_t              e;
        logic [`BTB_IDX_W-1:0] idx;
        assert (exp_q.size() != 0)
            else report_failure("an update record arrived when none was expected");
        e = exp_q.pop_front();
        assert (upd_pc == e.pc)
            else report_failure($sformatf("ERROR: upd_pc %h expected %h", upd_pc, e.pc));
        assert (upd_taken == e.taken)
            else report_failure($sformatf("ERROR: upd_taken %h expected %h", upd_taken, e.taken));
        assert (upd_kind == e.kind)
            else report_failure($sformatf("ERROR: upd_kind %h expected %h", upd_kind, e.kind));
        assert (upd_target == e.target)
            else report_failure($sformatf("ERROR: upd_target %h expected %h",
                                          upd_target, e.target));
        exp_miss = (e.meta.taken != e.taken) ||
                   (e.meta.taken && e.taken && e.meta.npc != e.target);
        idx = e.pc[`BTB_IDX_W-1:0];
        if (e.taken) begin
            m_tgt[idx] = e.target;
            if (m_cnt[idx] != 2'b11) begin
                m_cnt[idx] = m_cnt[idx] + 2'b01;
            end
        end else if (m_cnt[idx] != 2'b00) begin
            m_cnt[idx] = m_cnt[idx] - 2'b01;
        end
    endtask

    task automatic check_lookups();
        for (int i = 0; i < ENTRIES; i++) begin
            @(posedge clk);
            lookup_pc <= PC_W'('h1230 + i);    // upper bits ignored by the index
            @(negedge clk);
            assert (lookup_taken == m_cnt[i][1])
                else report_failure($sformatf("ERROR: lookup_taken %h expected %h at index %h",
                                              lookup_taken, m_cnt[i][1], i));
            assert (lookup_target == m_tgt[i])
                else report_failure($sformatf("ERROR: lookup_target %h expected %h",
                                              lookup_target, m_tgt[i]));
        end
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            exp_miss = 1'b0;
            for (int i = 0; i < ENTRIES; i++) begin
                m_cnt[i] = 2'b01;
                m_tgt[i] = '0;
            end
        end else begin
            assert (mispredict == exp_miss)
                else report_failure($sformatf("ERROR: mispredict %h expected %h",
                                              mispredict, exp_miss));
            exp_miss = 1'b0;
            if (upd_valid) begin
                check_record();
            end
        end
    end

    initial begin
        void'($urandom(32'h398e_f8c0));
        rstn      = 1'b0;
        stall     = 1'b1;
        dual      = 1'b0;
        lane0     = '0;
        lane1     = '0;
        lookup_pc = '0;
        build_table();
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (upd_valid == 1'b0)
            else report_failure($sformatf("ERROR: upd_valid %h expected 0", upd_valid));
        check_lookups();
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        @(posedge clk);
        stall <= 1'b1;
        dual  <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);   // last mispredict pulse
        assert (stream.size() == 0)
            else report_failure("lane results were left over without a pack");
        check_lookups();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tb/bp_update_assertions.sv
// concurrent checks on the merge queue, bound into every update_merge_buffer instance
`timescale 1ns/1ns
`include "bp_params.svh"

module bp_update_assertions #(
    parameter int CNT_W = 3
) (
    input logic             clk,
    input logic             rstn,
    input logic [CNT_W-1:0] count,
    input logic             valid0,
    input logic             valid1,
    input logic             upd_valid
);

    occupancy_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= CNT_W'(`BUF_DEPTH))
        else $error("merge queue holds %0d entries, above its depth", count);

    quiet_in_reset: assert property (@(posedge clk) !rstn |-> !upd_valid)
        else $error("update strobe while in reset");

    // lane 1 never arrives alone
    lane_order: assert property (@(posedge clk) disable iff (!rstn) valid1 |-> valid0)
        else $error("slot valid1 without valid0");

    no_pop_from_empty: assert property (@(posedge clk) disable iff (!rstn)
        count == '0 |=> !upd_valid)
        else $error("update record after an empty queue");

endmodule

bind update_merge_buffer bp_update_assertions #(
    .CNT_W (CNT_W)
) i_bp_update_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .count     (count),
    .valid0    (slot.valid0),
    .valid1    (slot.valid1),
    .upd_valid (upd_valid_q)
);

// File: src/bp_update_top.sv
// top level of the predictor update path: lanes in, update records and lookups out
`timescale 1ns/1ns
`include "bp_params.svh"

module bp_update_top (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             dual,
    input  logic             lane0_pred_taken,
    input  logic [2:0]       lane0_pred_kind,
    input  logic [`PC_W-1:0] lane0_pred_npc,
    input  logic [1:0]       lane0_pred_choice,
    input  logic             lane0_taken,
    input  logic [2:0]       lane0_kind,
    input  logic [`PC_W-1:0] lane0_npc,
    input  logic [`PC_W-1:0] lane0_pc,
    input  logic             lane0_cut,
    input  logic             lane1_pred_taken,
    input  logic [2:0]       lane1_pred_kind,
    input  logic [`PC_W-1:0] lane1_pred_npc,
    input  logic [1:0]       lane1_pred_choice,
    input  logic             lane1_taken,
    input  logic [2:0]       lane1_kind,
    input  logic [`PC_W-1:0] lane1_npc,
    input  logic [`PC_W-1:0] lane1_pc,
    input  logic             lane1_cut,
    output logic             upd_valid,
    output logic [`PC_W-1:0] upd_pc,
    output logic             upd_taken,
    output logic [2:0]       upd_kind,
    output logic [`PC_W-1:0] upd_target,
    output logic             mispredict,
    input  logic [`PC_W-1:0] lookup_pc,
    output logic             lookup_taken,
    output logic [`PC_W-1:0] lookup_target
);
    import ex_pkg::*;

    lane_result_t lane0;
    lane_result_t lane1;

    ex_slot_if slot_bus ();
    bp_upd_if  upd_bus ();

    // field order follows lane_result_t
    assign lane0 = {lane0_cut, lane0_pc, lane0_npc, lane0_kind, lane0_taken,
                    lane0_pred_choice, lane0_pred_npc, lane0_pred_kind, lane0_pred_taken};
    assign lane1 = {lane1_cut, lane1_pc, lane1_npc, lane1_kind, lane1_taken,
                    lane1_pred_choice, lane1_pred_npc, lane1_pred_kind, lane1_pred_taken};

    ex_collect i_ex_collect (
        .clk   (clk),
        .rstn  (rstn),
        .stall (stall),
        .dual  (dual),
        .lane0 (lane0),
        .lane1 (lane1),
        .slot  (slot_bus.collect)
    );

    update_merge_buffer i_update_merge_buffer (
        .clk  (clk),
        .rstn (rstn),
        .slot (slot_bus.buffer),
        .upd  (upd_bus.merge)
    );

    predictor_update i_predictor_update (
        .clk           (clk),
        .rstn          (rstn),
        .upd           (upd_bus.tbl),
        .lookup_pc     (lookup_pc),
        .lookup_taken  (lookup_taken),
        .lookup_target (lookup_target),
        .mispredict    (mispredict)
    );

    assign upd_valid  = upd_bus.upd_valid;
    assign upd_pc     = upd_bus.rec.pc;
    assign upd_taken  = upd_bus.rec.taken;
    assign upd_kind   = upd_bus.rec.kind;
    assign upd_target = upd_bus.rec.target;

endmodule

// File: src/predictor_update.sv
// direct-mapped target buffer and 2-bit direction counters trained by merged records
`timescale 1ns/1ns
`include "bp_params.svh"

module predictor_update (
    input  logic             clk,
    input  logic             rstn,
    bp_upd_if.tbl            upd,
    input  logic [`PC_W-1:0] lookup_pc,
    output logic             lookup_taken,
    output logic [`PC_W-1:0] lookup_target,
    output logic             mispredict
);
    import ex_pkg::*;

    localparam int ENTRIES = 1 << `BTB_IDX_W;

    logic [1:0]            cnt [ENTRIES];
    logic [`PC_W-1:0]      tgt [ENTRIES];
    upd_rec_t              rec;
    logic [`BTB_IDX_W-1:0] upd_idx;
    logic [`BTB_IDX_W-1:0] look_idx;
    logic                  miss;

    assign rec      = upd.rec;
    assign upd_idx  = rec.pc[`BTB_IDX_W-1:0];
    assign look_idx = lookup_pc[`BTB_IDX_W-1:0];

    // wrong direction, or right direction to the wrong place
    assign miss = (rec.meta.taken != rec.taken) ||
                  (rec.meta.taken && rec.taken && rec.meta.npc != rec.target);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                cnt[i] <= 2'b01;    // weakly not taken
                tgt[i] <= '0;
            end
        end else if (upd.upd_valid) begin
            if (rec.taken && cnt[upd_idx] != 2'b11) begin
                cnt[upd_idx] <= cnt[upd_idx] + 2'b01;
            end else if (!rec.taken && cnt[upd_idx] != 2'b00) begin
                cnt[upd_idx] <= cnt[upd_idx] - 2'b01;
            end
            if (rec.taken) begin
                tgt[upd_idx] <= rec.target;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mispredict <= 1'b0;
        end else begin
            mispredict <= upd.upd_valid & miss;   // one cycle after the update
        end
    end

    assign lookup_taken  = cnt[look_idx][1];
    assign lookup_target = tgt[look_idx];

endmodule

// File: src/update_merge_buffer.sv
// program-ordered queue of lane results; pops one fetch pack per cycle as a merged record
`timescale 1ns/1ns
`include "bp_params.svh"

module update_merge_buffer (
    input  logic      clk,
    input  logic      rstn,
    ex_slot_if.buffer slot,
    bp_upd_if.merge   upd
);
    import bp_pkg::*;
    import ex_pkg::*;

    localparam int DEPTH = `BUF_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 3);   // headroom so overflow is visible

    lane_result_t     q      [DEPTH];   // q[0] is the oldest entry
    lane_result_t     q_next [DEPTH];
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] keep;             // entries left after the pop
    logic [1:0]       n_pop;
    logic [1:0]       n_push;
    lane_result_t     older;
    lane_result_t     younger;
    upd_rec_t         rec_d;
    upd_rec_t         rec_q;
    logic             upd_valid_q;

    // kind of a pair, highest priority wins
    function automatic br_kind_t merge_kind(input br_kind_t a, input br_kind_t b);
        br_kind_t k;
        if (a == direct_jump || b == direct_jump) begin
            k = direct_jump;
        end else if (a == call || b == call) begin
            k = call;
        end else if (a == ret || b == ret) begin
            k = ret;
        end else if (a == indirect_jump || b == indirect_jump) begin
            k = indirect_jump;
        end else if (a == other_jump || b == other_jump) begin
            k = other_jump;
        end else begin
            k = not_jump;
        end
        return k;
    endfunction

    assign older   = q[0];
    assign younger = q[1];

    always_comb begin
        if (count != '0 && older.cut) begin
            n_pop = 2'd1;                       // pack ends at the head
        end else if (count >= CNT_W'(2)) begin
            n_pop = 2'd2;
        end else begin
            n_pop = 2'd0;                       // wait for the younger half
        end
    end

    assign n_push = {1'b0, slot.valid0} + {1'b0, slot.valid1};
    assign keep   = count - CNT_W'(n_pop);

    // shift out the popped pack, append new slots behind the survivors
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            q_next[i] = q[i];
            if (i + n_pop < DEPTH) begin
                q_next[i] = q[i + n_pop];
            end
        end
        if (slot.valid0 && keep < CNT_W'(DEPTH)) begin
            q_next[keep] = slot.slot0;
        end
        if (slot.valid1 && keep + CNT_W'(1) < CNT_W'(DEPTH)) begin
            q_next[keep + CNT_W'(1)] = slot.slot1;
        end
    end

    always_comb begin
        rec_d.pc   = older.pc;
        rec_d.meta = older.meta;
        if (n_pop == 2'd2) begin
            rec_d.taken  = older.taken | younger.taken;
            rec_d.kind   = merge_kind(older.kind, younger.kind);
            rec_d.target = older.taken ? older.npc : younger.npc;  // first taken
        end else begin
            rec_d.taken  = older.taken;
            rec_d.kind   = older.kind;
            rec_d.target = older.npc;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count       <= '0;
            upd_valid_q <= 1'b0;
        end else begin
            count       <= keep + CNT_W'(n_push);
            upd_valid_q <= (n_pop != 2'd0);
        end
    end

    always_ff @(posedge clk) begin
        q <= q_next;
        if (n_pop != 2'd0) begin
            rec_q <= rec_d;
        end
    end

    assign upd.upd_valid = upd_valid_q;
    assign upd.rec       = rec_q;

endmodule

// File: src/ex_collect.sv
// registers both execute lanes and qualifies them by stall and lane count for the queue
`timescale 1ns/1ns

module ex_collect (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 stall,
    input  logic                 dual,     // lane 1 carries a result too
    input  ex_pkg::lane_result_t lane0,
    input  ex_pkg::lane_result_t lane1,
    ex_slot_if.collect           slot
);
    import ex_pkg::*;

    logic         valid0_q;
    logic         valid1_q;
    lane_result_t slot0_q;
    lane_result_t slot1_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else begin
            valid0_q <= ~stall;
            valid1_q <= ~stall & dual;
        end
    end

    // lane payload, captured only when it will be enqueued
    always_ff @(posedge clk) begin
        if (!stall) begin
            slot0_q <= lane0;
            if (dual) begin
                slot1_q <= lane1;
            end
        end
    end

    assign slot.valid0 = valid0_q;
    assign slot.valid1 = valid1_q;
    assign slot.slot0  = slot0_q;
    assign slot.slot1  = slot1_q;

endmodule

// File: src/bp_upd_if.sv
// carries merged update records from the merge queue into the predictor tables
`timescale 1ns/1ns

interface bp_upd_if;
    import ex_pkg::*;

    logic     upd_valid;    // one cycle per record
    upd_rec_t rec;          // write data, valid with upd_valid

    modport merge (
        output upd_valid, rec
    );

    // table side of the update path
    modport tbl (
        input upd_valid, rec
    );

endinterface

// File: src/ex_slot_if.sv
// carries the registered lane results from the collector into the merge queue
`timescale 1ns/1ns

interface ex_slot_if;
    import ex_pkg::*;

    logic         valid0;
    logic         valid1;   // never without valid0
    lane_result_t slot0;    // older instruction
    lane_result_t slot1;

    modport collect (
        output valid0, valid1, slot0, slot1
    );

    modport buffer (
        input valid0, valid1, slot0, slot1
    );

endinterface

// File: src/ex_pkg.sv
// execute-side types: one resolved lane result and the merged record per fetch pack
`include "bp_params.svh"

package ex_pkg;
    import bp_pkg::*;

    // 101 bits
    typedef struct packed {
        logic             cut;      // younger of the pack was flushed
        logic [`PC_W-1:0] pc;
        logic [`PC_W-1:0] npc;      // resolved next pc
        br_kind_t         kind;
        logic             taken;
        pred_meta_t       meta;
    } lane_result_t;

    typedef struct packed {
        logic [`PC_W-1:0] pc;       // older instruction of the pack
        pred_meta_t       meta;
        logic             taken;
        br_kind_t         kind;
        logic [`PC_W-1:0] target;
    } upd_rec_t;

endpackage

// File: src/bp_pkg.sv
// predictor-side types: branch kind encoding and the metadata a prediction carries
`include "bp_params.svh"

package bp_pkg;

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        call          = 3'd2,
        ret           = 3'd3,
        indirect_jump = 3'd4,
        other_jump    = 3'd5
    } br_kind_t;

    // what fetch guessed for one instruction, 36 bits
    typedef struct packed {
        logic [1:0]       choice;   // chooser counter at predict time
        logic [`PC_W-1:0] npc;
        br_kind_t         kind;
        logic             taken;
    } pred_meta_t;

endpackage

// File: src/bp_params.svh
// size macros for the branch predictor update path, included by every file that needs them
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// word-aligned pc width
`define PC_W 30

// merge queue entries
`define BUF_DEPTH 5

// target buffer and counter index, 16 entries
`define BTB_IDX_W 4

`endif
